// ==== logic/camera_pkg.sv ====
// Shared definitions for the camera SPI control path
// Register map, default widths, SPI command and metering structs

`default_nettype none

package camera_pkg;

    // Register addresses as seen in the SPI opcode byte
    localparam logic [7:0] START_CAPTURE     = 8'h20; // Write, restarts capture
    localparam logic [7:0] BYTES_REMAINING   = 8'h21; // Read, two bytes
    localparam logic [7:0] IMAGE_DATA        = 8'h22; // Read, auto increment
    localparam logic [7:0] ZOOM              = 8'h23; // Write, ignored
    localparam logic [7:0] PAN               = 8'h24; // Write, ignored
    localparam logic [7:0] METERING          = 8'h25; // Read, six bytes
    localparam logic [7:0] QUALITY_FACTOR    = 8'h26; // Write
    localparam logic [7:0] IMAGE_READY_FLAG  = 8'h27; // Read
    localparam logic [7:0] POWER_SAVE_ENABLE = 8'h28; // Write

    // Default sizes
    localparam int IMAGE_ADDRESS_WIDTH_DEFAULT = 16; // Image address and size
    localparam int OPERAND_COUNT_WIDTH_DEFAULT = 8;  // Operand bytes per transaction

    // Command from the SPI peripheral to the register block
    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] operand;
        logic       operand_valid; // Operand byte received
        logic       operand_read;  // Response byte sent
        logic [OPERAND_COUNT_WIDTH_DEFAULT-1:0] operand_count;
    } spi_command_t;

    // Metering values, in register read order
    typedef struct packed {
        logic [7:0] red_center;
        logic [7:0] green_center;
        logic [7:0] blue_center;
        logic [7:0] red_average;
        logic [7:0] green_average;
        logic [7:0] blue_average;
    } metering_t;

endpackage

`default_nettype wire

// ==== logic/spi_peripheral.sv ====
// SPI mode 0 slave
// Pin synchronizers, byte framing, command strobes and response shifter

`timescale 1ns/1ps
`default_nettype none

module spi_peripheral #(
    parameter int OPERAND_COUNT_WIDTH = camera_pkg::OPERAND_COUNT_WIDTH_DEFAULT
) (
    input  logic                    clock_in,
    input  logic                    reset_n_in,
    input  logic                    spi_clock,
    input  logic                    spi_select_n,
    input  logic                    spi_data_in,
    output logic                    spi_data_out,
    output camera_pkg::spi_command_t command,
    input  logic [7:0]              response
);
    import camera_pkg::*;

    logic [2:0] clock_sync;  // Two sync flops plus edge history
    logic [1:0] select_sync;
    logic [1:0] data_sync;
    logic       selected;
    logic       spi_rise;
    logic       spi_fall;
    logic [2:0] bit_count;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic       byte_done;
    logic       byte_stage;
    logic       first_byte;
    logic [7:0] opcode_q;
    logic [7:0] operand_q;
    logic       operand_pulse;
    logic [OPERAND_COUNT_WIDTH-1:0] operand_count_q;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            clock_sync  <= '0;
            select_sync <= 2'b11; // Deselected
            data_sync   <= '0;
        end else begin
            clock_sync  <= {clock_sync[1:0], spi_clock};
            select_sync <= {select_sync[0], spi_select_n};
            data_sync   <= {data_sync[0], spi_data_in};
        end
    end

    assign selected = ~select_sync[1];
    assign spi_rise = selected & clock_sync[1] & ~clock_sync[2];
    assign spi_fall = selected & ~clock_sync[1] & clock_sync[2];

    // Bit counter, byte_done marks the rise of bit 0
    always_ff @(posedge clock_in) begin
        if (!reset_n_in || !selected) begin
            bit_count <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= spi_rise && (bit_count == 3'd7);
            if (spi_rise) begin
                bit_count <= bit_count + 3'd1;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (spi_rise) begin
            rx_shift <= {rx_shift[6:0], data_sync[1]}; // MSB first
        end
        if (byte_stage && !first_byte) begin
            operand_q <= rx_shift;
        end
    end

    // Extra stage puts the strobes three cycles after the edge
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            byte_stage      <= 1'b0;
            first_byte      <= 1'b1;
            opcode_q        <= '0;
            operand_pulse   <= 1'b0;
            operand_count_q <= '0;
        end else begin
            byte_stage    <= byte_done;
            operand_pulse <= 1'b0;
            if (!selected) begin
                first_byte      <= 1'b1;
                operand_count_q <= '0;
            end else begin
                if (byte_stage) begin
                    first_byte <= 1'b0;
                    if (first_byte) begin
                        opcode_q <= rx_shift;
                    end else begin
                        operand_pulse <= 1'b1;
                    end
                end
                if (operand_pulse) begin
                    operand_count_q <= operand_count_q + 1'b1; // Next byte index
                end
            end
        end
    end

    // Response enters at the first falling edge of each byte
    always_ff @(posedge clock_in) begin
        if (!reset_n_in || !selected) begin
            tx_shift     <= '0;
            spi_data_out <= 1'b0;
        end else if (spi_fall) begin
            if (bit_count == 3'd0) begin
                spi_data_out <= response[7];
                tx_shift     <= {response[6:0], 1'b0};
            end else begin
                spi_data_out <= tx_shift[7];
                tx_shift     <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    always_comb begin
        command.opcode        = opcode_q;
        command.operand       = operand_q;
        command.operand_valid = operand_pulse;
        command.operand_read  = operand_pulse; // Same boundary for reads
        command.operand_count = OPERAND_COUNT_WIDTH_DEFAULT'(operand_count_q);
    end

endmodule

`default_nettype wire

// ==== logic/capture_buffer.sv ====
// Image byte store for the compressed frame
// Write counter, frame end handling, ready flag and read port

`timescale 1ns/1ps
`default_nettype none

module capture_buffer #(
    parameter int IMAGE_ADDRESS_WIDTH = camera_pkg::IMAGE_ADDRESS_WIDTH_DEFAULT
) (
    input  logic                           clock_in,
    input  logic                           reset_n_in,
    input  logic                           start_capture,
    input  logic [7:0]                     image_byte,
    input  logic                           image_byte_valid,
    input  logic                           frame_end,
    input  logic [IMAGE_ADDRESS_WIDTH-1:0] image_address,
    output logic [7:0]                     image_data,
    output logic [IMAGE_ADDRESS_WIDTH-1:0] image_total_size,
    output logic                           image_ready
);

    localparam int DEPTH = 2 ** IMAGE_ADDRESS_WIDTH;

    logic [7:0]                     image_memory [DEPTH];
    logic [IMAGE_ADDRESS_WIDTH-1:0] write_count;
    logic                           capturing;
    logic                           buffer_full;
    logic                           write_enable;

    // Count stops at all ones so it always fits the size field
    assign buffer_full  = &write_count;
    assign write_enable = capturing & image_byte_valid & ~buffer_full; // Late bytes dropped

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            capturing        <= 1'b0;
            write_count      <= '0;
            image_total_size <= '0;
            image_ready      <= 1'b0;
        end else if (start_capture) begin
            capturing        <= 1'b1;
            write_count      <= '0;
            image_total_size <= '0;
            image_ready      <= 1'b0;
        end else begin
            if (write_enable) begin
                write_count <= write_count + 1'b1;
            end
            if (capturing && frame_end) begin
                capturing   <= 1'b0;
                image_ready <= 1'b1;
                // Byte arriving with frame_end still counts
                image_total_size <= write_count + IMAGE_ADDRESS_WIDTH'(write_enable);
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            image_memory[write_count] <= image_byte;
        end
    end

    // Reads past the end of the image return zero
    assign image_data = (image_address < image_total_size) ? image_memory[image_address]
                                                           : 8'd0;

endmodule

`default_nettype wire

// ==== logic/spi_registers.sv ====
// Camera register block behind the SPI peripheral
// Opcode decode, response mux, capture start, image pointer, controls

`timescale 1ns/1ps
`default_nettype none

module spi_registers #(
    parameter int IMAGE_ADDRESS_WIDTH = camera_pkg::IMAGE_ADDRESS_WIDTH_DEFAULT,
    parameter int OPERAND_COUNT_WIDTH = camera_pkg::OPERAND_COUNT_WIDTH_DEFAULT
) (
    input  logic                           clock_in,
    input  logic                           reset_n_in,
    input  camera_pkg::spi_command_t       command,
    output logic [7:0]                     response,
    output logic                           start_capture,
    output logic [1:0]                     compression_factor,
    output logic                           power_save_enable,
    input  logic                           image_ready,
    input  logic [IMAGE_ADDRESS_WIDTH-1:0] image_total_size,
    input  logic [7:0]                     image_data,
    output logic [IMAGE_ADDRESS_WIDTH-1:0] image_address,
    input  camera_pkg::metering_t          metering
);
    import camera_pkg::*;

    logic [IMAGE_ADDRESS_WIDTH-1:0] bytes_remaining;
    logic [15:0]                    remaining_word;
    logic [OPERAND_COUNT_WIDTH-1:0] operand_index;
    logic [2:0]                     metering_index;

    assign bytes_remaining = image_total_size - image_address;
    assign remaining_word  = 16'(bytes_remaining); // Always sent as two bytes
    assign operand_index   = OPERAND_COUNT_WIDTH'(command.operand_count);

    // Counts past the last field keep returning blue_average
    always_comb begin
        if (operand_index < OPERAND_COUNT_WIDTH'(5)) begin
            metering_index = 3'(operand_index);
        end else begin
            metering_index = 3'd5;
        end
    end

    always_comb begin
        case (command.opcode)
            BYTES_REMAINING: begin
                if (operand_index == '0) begin
                    response = remaining_word[15:8]; // High byte first
                end else begin
                    response = remaining_word[7:0];
                end
            end
            IMAGE_DATA: response = image_data;
            METERING: begin
                case (metering_index)
                    3'd0:    response = metering.red_center;
                    3'd1:    response = metering.green_center;
                    3'd2:    response = metering.blue_center;
                    3'd3:    response = metering.red_average;
                    3'd4:    response = metering.green_average;
                    default: response = metering.blue_average;
                endcase
            end
            IMAGE_READY_FLAG: response = {7'd0, image_ready};
            default:          response = 8'd0;
        endcase
    end

    // Pulse in the same cycle as the operand strobe
    assign start_capture = command.operand_valid && (command.opcode == START_CAPTURE);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            compression_factor <= 2'd0;
            power_save_enable  <= 1'b1; // Wake up in power save
            image_address      <= '0;
        end else begin
            if (command.operand_read && command.opcode == IMAGE_DATA) begin
                if (image_address < image_total_size) begin
                    image_address <= image_address + 1'b1;
                end
            end
            if (command.operand_valid) begin
                case (command.opcode)
                    START_CAPTURE:     image_address <= '0;
                    ZOOM, PAN: begin
                        // Accepted, no zoom or pan hardware yet
                    end
                    QUALITY_FACTOR:    compression_factor <= command.operand[1:0];
                    POWER_SAVE_ENABLE: power_save_enable <= command.operand[0];
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/camera_top.sv ====
// Camera SPI control top level
// SPI peripheral, register block and capture buffer

`timescale 1ns/1ps
`default_nettype none

module camera_top #(
    parameter int IMAGE_ADDRESS_WIDTH = camera_pkg::IMAGE_ADDRESS_WIDTH_DEFAULT,
    parameter int OPERAND_COUNT_WIDTH = camera_pkg::OPERAND_COUNT_WIDTH_DEFAULT
) (
    input  logic                  clock_in,
    input  logic                  reset_n_in,
    input  logic                  spi_clock,
    input  logic                  spi_select_n,
    input  logic                  spi_data_in,
    output logic                  spi_data_out,
    input  logic [7:0]            image_byte,       // From the encoder
    input  logic                  image_byte_valid,
    input  logic                  frame_end,
    input  camera_pkg::metering_t metering,
    output logic [1:0]            compression_factor,
    output logic                  power_save_enable
);
    import camera_pkg::*;

    spi_command_t                   command;
    logic [7:0]                     response;
    logic                           start_capture;
    logic [IMAGE_ADDRESS_WIDTH-1:0] image_address;
    logic [IMAGE_ADDRESS_WIDTH-1:0] image_total_size;
    logic [7:0]                     image_data;
    logic                           image_ready;

    spi_peripheral #(
        .OPERAND_COUNT_WIDTH(OPERAND_COUNT_WIDTH)
    ) spi_peripheral_inst (
        .clock_in    (clock_in),
        .reset_n_in  (reset_n_in),
        .spi_clock   (spi_clock),
        .spi_select_n(spi_select_n),
        .spi_data_in (spi_data_in),
        .spi_data_out(spi_data_out),
        .command     (command),
        .response    (response)
    );

    spi_registers #(
        .IMAGE_ADDRESS_WIDTH(IMAGE_ADDRESS_WIDTH),
        .OPERAND_COUNT_WIDTH(OPERAND_COUNT_WIDTH)
    ) spi_registers_inst (
        .clock_in          (clock_in),
        .reset_n_in        (reset_n_in),
        .command           (command),
        .response          (response),
        .start_capture     (start_capture),
        .compression_factor(compression_factor),
        .power_save_enable (power_save_enable),
        .image_ready       (image_ready),
        .image_total_size  (image_total_size),
        .image_data        (image_data),
        .image_address     (image_address),
        .metering          (metering)
    );

    capture_buffer #(
        .IMAGE_ADDRESS_WIDTH(IMAGE_ADDRESS_WIDTH)
    ) capture_buffer_inst (
        .clock_in        (clock_in),
        .reset_n_in      (reset_n_in),
        .start_capture   (start_capture),
        .image_byte      (image_byte),
        .image_byte_valid(image_byte_valid),
        .frame_end       (frame_end),
        .image_address   (image_address),
        .image_data      (image_data),
        .image_total_size(image_total_size),
        .image_ready     (image_ready)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// Free running clock for the testbench

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clock_in
);

    initial begin
        clock_in = 1'b0;
        forever #(PERIOD_NS / 2) clock_in = ~clock_in;
    end

endmodule

`default_nettype wire

// ==== test/camera_checker.sv ====
// Response checker for the camera testbench
// Rebuilds SPI read bytes, compares them and the control outputs, prints results

`timescale 1ns/1ps
`default_nettype none

module camera_checker #(
    parameter int MAX_READ = 16
) (
    input  logic       clock_in,
    input  logic       spi_clock,
    input  logic       spi_select_n,
    input  logic       spi_data_out,
    input  logic [1:0] compression_factor,
    input  logic       power_save_enable,
    input  logic       read_active,
    input  logic [7:0] expected_bytes [MAX_READ],
    input  int         expected_length,
    input  logic       control_check,
    input  logic [1:0] expected_factor,
    input  logic       expected_power_save,
    input  logic       test_done,
    input  int         test_number,
    input  logic [7:0] test_opcode,
    output int         error_count,
    output int         test_count
);

    logic       spi_clock_last;
    logic [7:0] received_byte;
    int         bit_count;
    int         byte_index;
    int         test_errors;

    task automatic compare(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            test_errors++;
            error_count++;
        end
    endtask

    initial begin
        spi_clock_last = 1'b0;
        received_byte  = 8'h00;
        bit_count      = 0;
        byte_index     = 0;
        test_errors    = 0;
        error_count    = 0;
        test_count     = 0;
    end

    always @(posedge clock_in) begin
        if (spi_select_n) begin
            bit_count  = 0;
            byte_index = 0;
        end else if (spi_clock && !spi_clock_last) begin
            received_byte = {received_byte[6:0], spi_data_out}; // MSB first
            bit_count++;
            if (bit_count == 8) begin
                // Byte 0 carries the opcode, responses start after it
                if (read_active && byte_index > 0 && byte_index <= expected_length) begin
                    compare("spi_data_out", expected_bytes[byte_index - 1], received_byte);
                end
                bit_count = 0;
                byte_index++;
            end
        end
        spi_clock_last = spi_clock;
        if (control_check) begin
            compare("compression_factor", {6'd0, expected_factor}, {6'd0, compression_factor});
            compare("power_save_enable", {7'd0, expected_power_save}, {7'd0, power_save_enable});
        end
        if (test_done) begin
            test_count++;
            $display("test %0d opcode %h: %0d mismatches", test_number, test_opcode, test_errors);
            test_errors = 0;
        end
    end

endmodule

`default_nettype wire

// ==== test/camera_tb.sv ====
// Testbench top for the camera SPI control path
// Command file playback, SPI master, frame stream, LFSR, reference state and timeout

`timescale 1ns/1ps
`default_nettype none

module camera_tb;
    import camera_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int MAX_READ  = 16;
    localparam int HALF_SPI  = 4; // Clocks per SPI half period

    logic       clock_in;
    logic       reset_n_in;
    logic       spi_clock;
    logic       spi_select_n;
    logic       spi_data_in;
    logic       spi_data_out;
    logic [7:0] image_byte;
    logic       image_byte_valid;
    logic       frame_end;
    metering_t  metering;
    logic [1:0] compression_factor;
    logic       power_save_enable;

    // Command table and values handed to the checker
    string      kinds [MAX_LINES];
    string      expects [MAX_LINES];
    logic [7:0] opcodes [MAX_LINES];
    int         values [MAX_LINES];
    int         line_count;
    logic [7:0] expected_bytes [MAX_READ];
    int         expected_length;
    logic       read_active;
    logic       control_check;
    logic       test_done;
    logic [1:0] expected_factor;
    logic       expected_power_save;
    int         test_number;
    logic [7:0] test_opcode;
    int         error_count;
    int         test_count;

    // Reference state of the camera
    logic [7:0]  frame_bytes [$];
    int          model_size;
    int          model_address;
    logic        model_ready;
    logic        model_capturing;
    logic [31:0] lfsr_state;
    int          cycle_count;
    int          cycle_limit;

    tb_clock #(.PERIOD_NS(20)) tb_clock_inst (.clock_in(clock_in));

    camera_top camera_top_inst (.*);

    camera_checker #(.MAX_READ(MAX_READ)) camera_checker_inst (.*);

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $finish;
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    function automatic logic [7:0] next_random_byte();
        logic [7:0] value;
        value = 8'h00;
        for (int b = 0; b < 8; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [7:0] metering_byte(input int index);
        case (index)
            0:       return metering.red_center;
            1:       return metering.green_center;
            2:       return metering.blue_center;
            3:       return metering.red_average;
            4:       return metering.green_average;
            default: return metering.blue_average; // Index 5 and up
        endcase
    endfunction

    // Reads the command file and works out the cycle budget
    function automatic bit load_commands();
        int    fd;
        int    fields;
        int    opcode_value;
        int    value;
        string line;
        string kind;
        string expect_text;
        fd = $fopen("test/camera_input.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        line_count  = 0;
        cycle_limit = 1000;
        while (!$feof(fd) && line_count < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %d %s", kind, opcode_value, value, expect_text);
            if (fields != 4) begin
                continue; // Blank line
            end
            if (kind == "write") begin
                cycle_limit += 2 * 80;
            end else if (kind == "read" && value > 0 && value <= MAX_READ) begin
                cycle_limit += (value + 1) * 80;
            end else if (kind == "frame") begin
                cycle_limit += value;
            end else if (kind != "check") begin
                $fclose(fd);
                return 1'b0;
            end
            kinds[line_count]   = kind;
            opcodes[line_count] = 8'(opcode_value);
            values[line_count]  = value;
            expects[line_count] = expect_text;
            line_count++;
        end
        $fclose(fd);
        return line_count > 0;
    endfunction

    // Expected response bytes, from the register rules unless listed
    function automatic void prepare_read(input logic [7:0] opcode, input int length,
                                         input string expect_text);
        logic [63:0] listed;
        logic [15:0] remaining;
        for (int i = 0; i < length; i++) begin
            remaining = 16'(model_size - model_address);
            if (opcode == IMAGE_DATA) begin
                expected_bytes[i] = 8'h00;
                if (model_address < model_size) begin
                    expected_bytes[i] = frame_bytes[model_address];
                    model_address++;
                end
            end else if (opcode == BYTES_REMAINING) begin
                expected_bytes[i] = (i == 0) ? remaining[15:8] : remaining[7:0];
            end else if (opcode == METERING) begin
                expected_bytes[i] = metering_byte(i);
            end else if (opcode == IMAGE_READY_FLAG) begin
                expected_bytes[i] = {7'd0, model_ready};
            end else begin
                expected_bytes[i] = 8'h00;
            end
        end
        if (expect_text != "X") begin
            void'($sscanf(expect_text, "%h", listed));
            for (int i = 0; i < length; i++) begin
                expected_bytes[i] = 8'(listed >> (8 * (length - 1 - i)));
            end
        end
        expected_length = length;
    endfunction

    task automatic send_byte(input logic [7:0] value);
        for (int b = 7; b >= 0; b--) begin
            spi_data_in = value[b];
            repeat (HALF_SPI) @(negedge clock_in);
            spi_clock = 1'b1;
            repeat (HALF_SPI) @(negedge clock_in);
            spi_clock = 1'b0;
        end
    endtask

    // One transaction, opcode then count copies of the operand
    task automatic spi_transfer(input logic [7:0] opcode, input int count,
                                input logic [7:0] operand);
        spi_select_n = 1'b0;
        send_byte(opcode);
        repeat (count) send_byte(operand);
        repeat (HALF_SPI) @(negedge clock_in);
        spi_select_n = 1'b1;
        repeat (2 * HALF_SPI) @(negedge clock_in);
    endtask

    task automatic run_frame(input int length);
        logic [7:0] value;
        for (int n = 0; n < length; n++) begin
            value            = next_random_byte();
            image_byte       = value;
            image_byte_valid = 1'b1;
            if (model_capturing && frame_bytes.size() < 65535) begin
                frame_bytes.push_back(value); // Full buffer drops the rest
            end
            @(negedge clock_in);
        end
        image_byte_valid = 1'b0;
        frame_end        = 1'b1;
        @(negedge clock_in);
        frame_end = 1'b0;
        if (model_capturing) begin
            model_size      = frame_bytes.size();
            model_ready     = 1'b1;
            model_capturing = 1'b0;
        end
    endtask

    task automatic run_line(input int index);
        if (kinds[index] == "write") begin
            spi_transfer(opcodes[index], 1, 8'(values[index]));
            if (opcodes[index] == START_CAPTURE) begin
                frame_bytes.delete();
                model_size      = 0;
                model_address   = 0;
                model_ready     = 1'b0;
                model_capturing = 1'b1;
            end
        end else if (kinds[index] == "read") begin
            prepare_read(opcodes[index], values[index], expects[index]);
            read_active = 1'b1;
            spi_transfer(opcodes[index], values[index], 8'h00);
            read_active = 1'b0;
        end else if (kinds[index] == "frame") begin
            run_frame(values[index]);
        end else begin
            expected_factor     = 2'(values[index]);
            expected_power_save = (expects[index] == "1");
            control_check       = 1'b1;
            @(negedge clock_in);
            control_check = 1'b0;
        end
    endtask

    always @(posedge clock_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("Timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        reset_n_in       = 1'b0;
        spi_clock        = 1'b0;
        spi_select_n     = 1'b1;
        spi_data_in      = 1'b0;
        image_byte       = 8'h00;
        image_byte_valid = 1'b0;
        frame_end        = 1'b0;
        metering         = {8'h3c, 8'h5a, 8'h7e, 8'h21, 8'h43, 8'h65};
        read_active      = 1'b0;
        control_check    = 1'b0;
        test_done        = 1'b0;
        expected_factor     = 2'd0;
        expected_power_save = 1'b0;
        expected_length     = 0;
        test_number      = 0;
        test_opcode      = 8'h00;
        lfsr_state       = 32'h819dabc4;
        model_size       = 0;
        model_address    = 0;
        model_ready      = 1'b0;
        model_capturing  = 1'b0;
        cycle_count      = 0;
        cycle_limit      = 0;
        if (!load_commands()) begin
            stop_with_failure("Could not read a valid command list from test/camera_input.txt");
        end else begin
            repeat (16) @(negedge clock_in);
            reset_n_in = 1'b1;
            repeat (4) @(negedge clock_in);
            for (int i = 0; i < line_count; i++) begin
                test_number = i + 1;
                test_opcode = opcodes[i];
                run_line(i);
                test_done = 1'b1;
                @(negedge clock_in);
                test_done = 1'b0;
            end
            @(negedge clock_in);
            $display("%0d tests, %0d mismatches", test_count, error_count);
            if (error_count == 0) begin
                $display("Simulation completed successfully");
                $finish;
            end else begin
                stop_with_failure("Mismatches were found");
            end
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/camera_pkg.sv
logic/spi_peripheral.sv
logic/capture_buffer.sv
logic/spi_registers.sv
logic/camera_top.sv
test/tb_clock.sv
test/camera_checker.sv
test/camera_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module camera_tb -f src.f -o camera_sim
	./obj_dir/camera_sim | awk '{ print } /Simulation completed successfully/ { found = 1 } END { exit !found }'

clean:
	rm -rf obj_dir

// ==== test/camera_input.txt ====
# kind opcode(hex) value(decimal: operand, read length or frame length) expect
# expect: read bytes in hex (X = from register rules), power_save_enable for check, - otherwise
check 00 0 1
read 27 1 00
read 21 2 0000
write 26 6 -
check 00 2 1
write 28 0 -
check 00 2 0
write 23 255 -
write 24 17 -
check 00 2 0
write 20 0 -
frame 00 300 -
read 27 1 01
read 21 2 012c
read 22 10 X
read 21 2 0122
write 20 0 -
read 27 1 00
read 21 2 0000
frame 00 12 -
read 27 1 01
read 21 2 000c
read 22 16 X
read 21 2 0000
read 25 7 X
